// File: rtl/ccm_pkg.sv
`default_nettype none

package ccm_pkg;

   //************************************************************
   // Widths and enables
   //************************************************************
   localparam int DATA_W      = 32;   // Data word
   localparam int ECC_W       = 7;    // Hamming c0..c5 plus overall parity
   localparam int CW_W        = 39;   // Full codeword
   localparam int BANK_DEPTH  = 1024; // Words per bank
   localparam bit DCCM_ENABLE = 1'b1;
   localparam bit ICCM_ENABLE = 1'b1;

   typedef logic [DATA_W-1:0]              data_t;
   typedef logic [ECC_W-1:0]               ecc_t;
   typedef logic [CW_W-1:0]                codeword_t;
   typedef logic [$clog2(BANK_DEPTH)-1:0]  bank_idx_t;  // Index inside one bank
   typedef logic [$clog2(BANK_DEPTH)-1:0]  dccm_addr_t; // One DCCM bank
   typedef logic [$clog2(BANK_DEPTH):0]    iccm_addr_t; // Even and odd banks

   //************************************************************
   // SECDED encoder
   //************************************************************
   // Data bits fill Hamming positions 1..38, skipping powers of two
   function automatic codeword_t ecc_encode(data_t d);
      ecc_t c;
      int   k;
      c = '0;
      k = 0;
      for (int pos = 1; pos < CW_W; pos++) begin
         if ((pos & (pos - 1)) != 0) begin // Data position
            for (int i = 0; i < ECC_W - 1; i++) begin
               if (pos[i]) c[i] = c[i] ^ d[k]; // Covered by check bit i
            end
            k++;
         end
      end
      c[ECC_W-1] = ^{c[ECC_W-2:0], d}; // Overall parity
      return {c, d};
   endfunction

endpackage

`default_nettype wire

// File: rtl/ccm_if.sv
`timescale 1ns/1ps
`default_nettype none

// Controller to storage bank link
interface ccm_if
   import ccm_pkg::*;
();

   logic      wren;    // Write strobe
   bank_idx_t wr_idx;
   codeword_t wr_cw;   // Encoded word to store
   logic      rden;    // Read strobe
   bank_idx_t rd_idx;
   codeword_t rd_cw;   // Registered read word

   modport requester (
      output wren, wr_idx, wr_cw,
      output rden, rd_idx,
      input  rd_cw
   );

   modport bank (
      input  wren, wr_idx, wr_cw,
      input  rden, rd_idx,
      output rd_cw
   );

endinterface

`default_nettype wire

// File: rtl/ccm_bank.sv
`timescale 1ns/1ps
`default_nettype none

module ccm_bank
   import ccm_pkg::*;
(
   input logic clk,
   ccm_if.bank bus
);

   //************************************************************
   // Storage array
   //************************************************************
   codeword_t mem [BANK_DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (bus.wren) begin
         mem[bus.wr_idx] <= bus.wr_cw;
      end
   end

   // Read port, one cycle latency
   // Output held between reads
   // Same-index write in same cycle gives the old word
   always_ff @(posedge clk) begin
      if (bus.rden) begin
         bus.rd_cw <= mem[bus.rd_idx];
      end
   end

endmodule

`default_nettype wire

// File: rtl/ecc_secded_dec.sv
`timescale 1ns/1ps
`default_nettype none

module ecc_secded_dec
   import ccm_pkg::*;
(
   input  codeword_t cw,
   input  logic      ecc_disable,
   output data_t     data,
   output logic      sb_err,
   output logic      db_err
);

   codeword_t        enc;       // Recomputed codeword
   logic [ECC_W-2:0] syndrome;  // Position of flipped bit
   logic             par_err;   // Odd number of flips
   logic             syn_nz;
   data_t            fixed;     // Corrected data

   //************************************************************
   // Syndrome and parity
   //************************************************************
   assign enc      = ecc_encode(cw[DATA_W-1:0]);
   assign syndrome = enc[DATA_W +: ECC_W-1] ^ cw[DATA_W +: ECC_W-1];
   assign par_err  = ^cw;                 // Over all 39 bits
   assign syn_nz   = |syndrome;

   // Flip the data bit named by the syndrome
   always_comb begin : p_correct
      int k;
      fixed = cw[DATA_W-1:0];
      k     = 0;
      for (int pos = 1; pos < CW_W; pos++) begin
         if ((pos & (pos - 1)) != 0) begin   // Data position only
            if (par_err && (int'(syndrome) == pos)) begin
               fixed[k] = ~fixed[k];
            end
            k++;
         end
      end
   end

   //************************************************************
   // Output selection
   //************************************************************
   // Check bit or parity bit hit leaves data untouched
   // Double error passes data uncorrected
   always_comb begin
      if (ecc_disable) begin
         data   = cw[DATA_W-1:0];  // Raw bits
         sb_err = 1'b0;
         db_err = 1'b0;
      end else begin
         data   = fixed;
         sb_err = par_err;
         db_err = syn_nz & ~par_err;  // Even flips, nonzero syndrome
      end
   end

endmodule

`default_nettype wire

// File: rtl/dccm_mem.sv
`timescale 1ns/1ps
`default_nettype none

module dccm_mem
   import ccm_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  logic       ecc_disable,
   input  logic       wren,
   input  logic       rden,
   input  dccm_addr_t wr_addr,
   input  dccm_addr_t rd_addr,
   input  data_t      wr_data,
   output data_t      rd_data,
   output logic       sb_err,
   output logic       db_err
);

   ccm_if bank_bus ();

   logic rd_valid;  // Read issued last cycle
   logic dec_sb;
   logic dec_db;

   //************************************************************
   // Bank request side
   //************************************************************
   assign bank_bus.wren   = wren;
   assign bank_bus.wr_idx = wr_addr;               // Word address is bank index
   assign bank_bus.wr_cw  = ecc_encode(wr_data);  // Encode on the way in
   assign bank_bus.rden   = rden;
   assign bank_bus.rd_idx = rd_addr;

   ccm_bank u_bank (
      .clk (clk),
      .bus (bank_bus)
   );

   // Check and correct the registered word
   ecc_secded_dec u_dec (
      .cw          (bank_bus.rd_cw),
      .ecc_disable (ecc_disable),
      .data        (rd_data),
      .sb_err      (dec_sb),
      .db_err      (dec_db)
   );

   // Flag qualifier
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rden;
      end
   end

   assign sb_err = dec_sb & rd_valid;  // Flags only for a fresh read
   assign db_err = dec_db & rd_valid;

endmodule

`default_nettype wire

// File: rtl/iccm_mem.sv
`timescale 1ns/1ps
`default_nettype none

module iccm_mem
   import ccm_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         ecc_disable,
   input  logic         wren,
   input  logic         wr_dw,        // Second codeword valid
   input  logic         rden,
   input  iccm_addr_t   rw_addr,
   input  logic [77:0]  wr_data,      // Two codewords
   output logic [63:0]  rd_data,      // Fetch group
   output logic [77:0]  rd_data_ecc,  // Raw codewords
   output logic [1:0]   sb_err,
   output logic [1:0]   db_err
);

   ccm_if bank_bus [2] ();  // 0 even, 1 odd

   logic       a0;          // Odd start word
   bank_idx_t  idx_base;    // A[10:1]
   bank_idx_t  idx_even;    // Bumped when A is odd
   logic       rd_go;       // Read not overridden by write
   logic       rd_valid;
   logic       a0_q;        // Order of returned words
   logic [1:0] bank_wren;
   codeword_t  bank_wr_cw [2];
   codeword_t  bank_rd_cw [2];
   data_t      bank_data  [2];
   logic [1:0] bank_sb;
   logic [1:0] bank_db;

   //************************************************************
   // Address split
   //************************************************************
   assign a0       = rw_addr[0];
   assign idx_base = rw_addr[$bits(iccm_addr_t)-1:1];
   assign idx_even = idx_base + bank_idx_t'(a0);  // 1023 wraps to 0
   assign rd_go    = rden & ~wren;                // Write wins

   // Word A in bank A[0], word A+1 in the other when double
   assign bank_wren[0]  = wren & (~a0 | wr_dw);
   assign bank_wren[1]  = wren & (a0 | wr_dw);
   assign bank_wr_cw[0] = a0 ? wr_data[77:39] : wr_data[38:0];
   assign bank_wr_cw[1] = a0 ? wr_data[38:0]  : wr_data[77:39];

   for (genvar i = 0; i < 2; i++) begin : g_bank
      assign bank_bus[i].wren   = bank_wren[i];
      assign bank_bus[i].wr_idx = (i == 0) ? idx_even : idx_base;
      assign bank_bus[i].wr_cw  = bank_wr_cw[i];
      assign bank_bus[i].rden   = rd_go;
      assign bank_bus[i].rd_idx = (i == 0) ? idx_even : idx_base;
      assign bank_rd_cw[i]      = bank_bus[i].rd_cw;

      ccm_bank u_bank (
         .clk (clk),
         .bus (bank_bus[i])
      );

      ecc_secded_dec u_dec (
         .cw          (bank_rd_cw[i]),
         .ecc_disable (ecc_disable),
         .data        (bank_data[i]),
         .sb_err      (bank_sb[i]),
         .db_err      (bank_db[i])
      );
   end

   //************************************************************
   // Read return
   //************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_valid <= 1'b0;
         a0_q     <= 1'b0;
      end else begin
         rd_valid <= rd_go;
         if (rd_go) a0_q <= a0;  // Held with the bank outputs
      end
   end

   // Word A low, word A+1 high
   assign rd_data     = {bank_data[~a0_q], bank_data[a0_q]};
   assign rd_data_ecc = {bank_rd_cw[~a0_q], bank_rd_cw[a0_q]};
   assign sb_err      = {bank_sb[~a0_q], bank_sb[a0_q]} & {2{rd_valid}};
   assign db_err      = {bank_db[~a0_q], bank_db[a0_q]} & {2{rd_valid}};

endmodule

`default_nettype wire

// File: rtl/ccm_mem.sv
`timescale 1ns/1ps
`default_nettype none

module ccm_mem
   import ccm_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         ecc_disable,    // Raw read data, no flags

   // DCCM ports
   input  logic         dccm_wren,
   input  logic         dccm_rden,
   input  dccm_addr_t   dccm_wr_addr,
   input  dccm_addr_t   dccm_rd_addr,
   input  data_t        dccm_wr_data,
   output data_t        dccm_rd_data,
   output logic         dccm_sb_err,
   output logic         dccm_db_err,

   // ICCM ports
   input  logic         iccm_wren,
   input  logic         iccm_wr_dw,
   input  logic         iccm_rden,      // Never with iccm_wren
   input  iccm_addr_t   iccm_rw_addr,
   input  logic [77:0]  iccm_wr_data,
   output logic [63:0]  iccm_rd_data,
   output logic [77:0]  iccm_rd_data_ecc,
   output logic [1:0]   iccm_sb_err,
   output logic [1:0]   iccm_db_err
);

   //************************************************************
   // DCCM
   //************************************************************
   if (DCCM_ENABLE) begin : g_dccm
      dccm_mem u_dccm (
         .clk         (clk),
         .rst_n       (rst_n),
         .ecc_disable (ecc_disable),
         .wren        (dccm_wren),
         .rden        (dccm_rden),
         .wr_addr     (dccm_wr_addr),
         .rd_addr     (dccm_rd_addr),
         .wr_data     (dccm_wr_data),
         .rd_data     (dccm_rd_data),
         .sb_err      (dccm_sb_err),
         .db_err      (dccm_db_err)
      );
   end else begin : g_no_dccm
      assign dccm_rd_data = '0;   // Memory absent
      assign dccm_sb_err  = 1'b0;
      assign dccm_db_err  = 1'b0;
   end

   //************************************************************
   // ICCM
   //************************************************************
   if (ICCM_ENABLE) begin : g_iccm
      iccm_mem u_iccm (
         .clk         (clk),
         .rst_n       (rst_n),
         .ecc_disable (ecc_disable),
         .wren        (iccm_wren),
         .wr_dw       (iccm_wr_dw),
         .rden        (iccm_rden),
         .rw_addr     (iccm_rw_addr),
         .wr_data     (iccm_wr_data),
         .rd_data     (iccm_rd_data),
         .rd_data_ecc (iccm_rd_data_ecc),
         .sb_err      (iccm_sb_err),
         .db_err      (iccm_db_err)
      );
   end else begin : g_no_iccm
      assign iccm_rd_data     = '0;
      assign iccm_rd_data_ecc = '0;
      assign iccm_sb_err      = '0;
      assign iccm_db_err      = '0;
   end

endmodule

`default_nettype wire

// File: tb/ccm_mem_props.sv
`timescale 1ns/1ps
`default_nettype none

module ccm_mem_props (
   input logic       clk,
   input logic       rst_n,
   input logic       dccm_rden,
   input logic       dccm_sb_err,
   input logic       dccm_db_err,
   input logic       iccm_rden,
   input logic       iccm_wren,
   input logic [1:0] iccm_sb_err,
   input logic [1:0] iccm_db_err
);

   //************************************************************
   // Handshake and flag rules
   //************************************************************
   a_iccm_no_rw : assert property (@(posedge clk) disable iff (!rst_n)
      !(iccm_rden && iccm_wren)) else $error("ICCM read and write in one cycle");

   a_dccm_idle : assert property (@(posedge clk) disable iff (!rst_n)
      !dccm_rden |=> (!dccm_sb_err && !dccm_db_err)) else $error("DCCM flag without read");

   a_iccm_idle : assert property (@(posedge clk) disable iff (!rst_n)
      !iccm_rden |=> (iccm_sb_err == 2'b00 && iccm_db_err == 2'b00))
      else $error("ICCM flag without read");

   // Single and double never together on one word
   a_excl : assert property (@(posedge clk) disable iff (!rst_n)
      !(dccm_sb_err && dccm_db_err) && ((iccm_sb_err & iccm_db_err) == 2'b00))
      else $error("Single and double flags both set");

   a_reset_clear : assert property (@(posedge clk) !rst_n |=>
      (!dccm_sb_err && !dccm_db_err && iccm_sb_err == 2'b00 && iccm_db_err == 2'b00))
      else $error("Flags set after reset");

endmodule

bind ccm_mem ccm_mem_props i_ccm_mem_props (.*);

`default_nettype wire

// File: tb/ccm_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ccm_mem_tb
   import ccm_pkg::*;
;

   localparam int CLK_NS      = 8;
   localparam int TEST_CYCLES = 250;                        // Rough sum over all tests
   localparam int WATCHDOG_NS = TEST_CYCLES * CLK_NS * 10;  // Wide margin

   logic         clk;
   logic         rst_n;
   logic         ecc_disable;
   logic         dccm_wren;
   logic         dccm_rden;
   dccm_addr_t   dccm_wr_addr;
   dccm_addr_t   dccm_rd_addr;
   data_t        dccm_wr_data;
   data_t        dccm_rd_data;
   logic         dccm_sb_err;
   logic         dccm_db_err;
   logic         iccm_wren;
   logic         iccm_wr_dw;
   logic         iccm_rden;
   iccm_addr_t   iccm_rw_addr;
   logic [77:0]  iccm_wr_data;
   logic [63:0]  iccm_rd_data;
   logic [77:0]  iccm_rd_data_ecc;
   logic [1:0]   iccm_sb_err;
   logic [1:0]   iccm_db_err;

   data_t        dccm_model [1024];  // Word model of each memory
   codeword_t    iccm_model [2048];
   codeword_t    forced_cw;          // Backdoor word for the DCCM bank
   logic [15:0]  lfsr_state = 16'd4095;

   ccm_mem i_ccm_mem (.*);

   //************************************************************
   // Clock, random source, reference encoder, check
   //************************************************************
   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   // Fibonacci LFSR, taps 16 14 13 11
   function automatic logic lfsr_bit();
      logic fb;
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic data_t rand_word();
      data_t w;
      for (int i = 0; i < DATA_W; i++) w[i] = lfsr_bit();  // One step per bit
      return w;
   endfunction

   // Walk data bits over positions 3, 5, 6, 7, 9, ...
   function automatic codeword_t encode_word(input data_t d);
      logic [5:0] c;
      int         pos;
      c   = '0;
      pos = 1;
      for (int k = 0; k < DATA_W; k++) begin
         while ((pos & (pos - 1)) == 0) pos++;  // Skip check positions
         for (int i = 0; i < 6; i++) begin
            if ((pos >> i) & 1) c[i] = c[i] ^ d[k];
         end
         pos++;
      end
      return {^{c, d}, c, d};  // Parity over data and c0..c5
   endfunction

   task automatic check(input string name, input logic [77:0] got, input logic [77:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
         $display("Errors found");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   //************************************************************
   // Bus helpers
   //************************************************************
   task automatic dccm_write(input dccm_addr_t a, input data_t d);
      @(negedge clk);
      dccm_wren     = 1'b1;
      dccm_wr_addr  = a;
      dccm_wr_data  = d;
      dccm_model[a] = d;
      @(negedge clk);
      dccm_wren     = 1'b0;
   endtask

   task automatic dccm_read_check(input dccm_addr_t a, input data_t exp,
                                  input logic exp_sb, input logic exp_db);
      @(negedge clk);
      dccm_rden    = 1'b1;
      dccm_rd_addr = a;
      @(negedge clk);
      dccm_rden    = 1'b0;  // Result already registered
      check("dccm_rd_data", dccm_rd_data, exp);
      check("dccm_sb_err", dccm_sb_err, exp_sb);
      check("dccm_db_err", dccm_db_err, exp_db);
   endtask

   task automatic iccm_write(input iccm_addr_t a, input codeword_t cw_lo,
                             input codeword_t cw_hi, input logic dw);
      @(negedge clk);
      iccm_wren     = 1'b1;
      iccm_wr_dw    = dw;
      iccm_rw_addr  = a;
      iccm_wr_data  = {cw_hi, cw_lo};
      iccm_model[a] = cw_lo;
      if (dw) iccm_model[iccm_addr_t'(a + 1)] = cw_hi;  // 2047 wraps to 0
      @(negedge clk);
      iccm_wren     = 1'b0;
      iccm_wr_dw    = 1'b0;
   endtask

   task automatic iccm_read_check(input iccm_addr_t a, input data_t exp_lo, input data_t exp_hi,
                                  input logic [1:0] exp_sb, input logic [1:0] exp_db);
      codeword_t cw_lo;
      codeword_t cw_hi;
      cw_lo = iccm_model[a];
      cw_hi = iccm_model[iccm_addr_t'(a + 1)];
      @(negedge clk);
      iccm_rden    = 1'b1;
      iccm_rw_addr = a;
      @(negedge clk);
      iccm_rden    = 1'b0;
      check("iccm_rd_data", iccm_rd_data, {exp_hi, exp_lo});
      check("iccm_rd_data_ecc", iccm_rd_data_ecc, {cw_hi, cw_lo});  // Raw, as stored
      check("iccm_sb_err", iccm_sb_err, exp_sb);
      check("iccm_db_err", iccm_db_err, exp_db);
   endtask

   task automatic iccm_clean_read(input iccm_addr_t a);
      iccm_read_check(a, iccm_model[a][31:0], iccm_model[iccm_addr_t'(a + 1)][31:0],
                      2'b00, 2'b00);
   endtask

   //************************************************************
   // Directed tests
   //************************************************************
   task automatic dccm_data_path();
      dccm_addr_t prev;
      for (int i = 0; i < 64; i++) begin  // Back-to-back writes
         @(negedge clk);
         dccm_wren    = 1'b1;
         dccm_wr_addr = dccm_addr_t'(i * 13);
         dccm_wr_data = rand_word();
         dccm_model[dccm_wr_addr] = dccm_wr_data;
      end
      for (int i = 0; i <= 64; i++) begin  // Read i issues while read i-1 is checked
         @(negedge clk);
         dccm_wren = 1'b0;
         if (i > 0) begin
            check("dccm_rd_data", dccm_rd_data, dccm_model[prev]);
            check("dccm_sb_err", dccm_sb_err, 1'b0);
            check("dccm_db_err", dccm_db_err, 1'b0);
         end
         if (i < 64) begin
            dccm_rden    = 1'b1;
            dccm_rd_addr = dccm_addr_t'(i * 13);
            prev         = dccm_rd_addr;
         end else begin
            dccm_rden    = 1'b0;
         end
      end
      @(negedge clk);
      check("dccm_rd_data", dccm_rd_data, dccm_model[prev]);  // Held after last read
      check("dccm_sb_err", dccm_sb_err, 1'b0);
   endtask

   task automatic dccm_same_cycle();
      data_t v;
      dccm_write(10'd900, rand_word());
      v = rand_word();
      @(negedge clk);
      dccm_wren    = 1'b1;  // Same index on both ports
      dccm_wr_addr = 10'd900;
      dccm_wr_data = v;
      dccm_rden    = 1'b1;
      dccm_rd_addr = 10'd900;
      @(negedge clk);
      dccm_wren    = 1'b0;
      dccm_rden    = 1'b0;
      check("dccm_rd_data", dccm_rd_data, dccm_model[900]);  // Old word
      dccm_model[900] = v;
      v = rand_word();
      @(negedge clk);
      dccm_wren    = 1'b1;  // Different indices
      dccm_wr_addr = 10'd901;
      dccm_wr_data = v;
      dccm_rden    = 1'b1;
      dccm_rd_addr = 10'd900;
      @(negedge clk);
      dccm_wren    = 1'b0;
      dccm_rden    = 1'b0;
      check("dccm_rd_data", dccm_rd_data, dccm_model[900]);
      dccm_model[901] = v;
      dccm_read_check(10'd901, v, 1'b0, 1'b0);
   endtask

   task automatic iccm_fetch_groups();
      iccm_write(11'd100, encode_word(rand_word()), encode_word(rand_word()), 1'b1);
      iccm_write(11'd102, encode_word(rand_word()), encode_word(rand_word()), 1'b1);
      // Single word, upper half must not land in word 103
      iccm_write(11'd102, encode_word(rand_word()), encode_word(rand_word()), 1'b0);
      iccm_write(11'd201, encode_word(rand_word()), encode_word(rand_word()), 1'b1);
      // Odd single word, word 202 kept
      iccm_write(11'd201, encode_word(rand_word()), encode_word(rand_word()), 1'b0);
      iccm_write(11'd2047, encode_word(rand_word()), encode_word(rand_word()), 1'b1);
      iccm_clean_read(11'd100);   // Even start
      iccm_clean_read(11'd101);   // Odd start
      iccm_clean_read(11'd102);   // Even single write
      iccm_clean_read(11'd201);   // Odd single write
      iccm_clean_read(11'd2047);  // Top word plus word 0
   endtask

   // Cases alternate between word 0 and word 1
   task automatic iccm_single_errors();
      int        flip [4] = '{5, 34, 38, 31};  // Data, check, parity, data
      data_t     d0;
      data_t     d1;
      codeword_t c0;
      codeword_t c1;
      for (int n = 0; n < 4; n++) begin
         d0 = rand_word();
         d1 = rand_word();
         c0 = encode_word(d0);
         c1 = encode_word(d1);
         if (n % 2 == 1) c1[flip[n]] = ~c1[flip[n]];
         else c0[flip[n]] = ~c0[flip[n]];
         iccm_write(iccm_addr_t'(600 + 3 * n), c0, c1, 1'b1);
         iccm_read_check(iccm_addr_t'(600 + 3 * n), d0, d1,
                         (n % 2 == 1) ? 2'b10 : 2'b01, 2'b00);
      end
   endtask

   task automatic iccm_double_errors();
      int        flip_a [3] = '{3, 0, 38};
      int        flip_b [3] = '{17, 35, 20};
      codeword_t c0;
      codeword_t c1;
      for (int n = 0; n < 3; n++) begin
         c0 = encode_word(rand_word());
         c1 = encode_word(rand_word());
         if (n == 1) begin
            c1[flip_a[n]] = ~c1[flip_a[n]];
            c1[flip_b[n]] = ~c1[flip_b[n]];
         end else begin
            c0[flip_a[n]] = ~c0[flip_a[n]];
            c0[flip_b[n]] = ~c0[flip_b[n]];
         end
         iccm_write(iccm_addr_t'(700 + 5 * n), c0, c1, 1'b1);
         iccm_read_check(iccm_addr_t'(700 + 5 * n), c0[31:0], c1[31:0],  // Uncorrected
                         2'b00, (n == 1) ? 2'b10 : 2'b01);
      end
   endtask

   task automatic ecc_off_reads();
      data_t     d;
      codeword_t c0;
      d  = rand_word();
      c0 = encode_word(d);
      c0[9] = ~c0[9];
      iccm_write(11'd800, c0, encode_word(d), 1'b1);
      ecc_disable = 1'b1;
      iccm_read_check(11'd800, c0[31:0], d, 2'b00, 2'b00);
      // DCCM encodes its own writes, so the bad word goes in on the bank side
      d         = rand_word();
      forced_cw = encode_word(d);
      forced_cw[12] = ~forced_cw[12];
      @(negedge clk);
      force i_ccm_mem.g_dccm.u_dccm.bank_bus.wr_cw = forced_cw;
      dccm_wren    = 1'b1;
      dccm_wr_addr = 10'd77;
      dccm_wr_data = d;
      @(negedge clk);
      dccm_wren    = 1'b0;
      release i_ccm_mem.g_dccm.u_dccm.bank_bus.wr_cw;
      dccm_read_check(10'd77, forced_cw[31:0], 1'b0, 1'b0);  // Raw bits
      ecc_disable = 1'b0;
      dccm_read_check(10'd77, d, 1'b1, 1'b0);  // Corrected once enabled again
   endtask

   //************************************************************
   // Sequence and watchdog
   //************************************************************
   initial begin
      rst_n        = 1'b0;
      ecc_disable  = 1'b0;
      dccm_wren    = 1'b0;
      dccm_rden    = 1'b0;
      dccm_wr_addr = '0;
      dccm_rd_addr = '0;
      dccm_wr_data = '0;
      iccm_wren    = 1'b0;
      iccm_wr_dw   = 1'b0;
      iccm_rden    = 1'b0;
      iccm_rw_addr = '0;
      iccm_wr_data = '0;
      forced_cw    = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      dccm_data_path();
      dccm_same_cycle();
      iccm_fetch_groups();
      iccm_single_errors();
      iccm_double_errors();
      ecc_off_reads();
      repeat (2) @(negedge clk);
      $display("No errors");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the tests finished");
      $display("Errors found");
      $fatal(1, "Timeout");
   end

endmodule

`default_nettype wire

// File: src.f
rtl/ccm_pkg.sv
rtl/ccm_if.sv
rtl/ccm_bank.sv
rtl/ecc_secded_dec.sv
rtl/dccm_mem.sv
rtl/iccm_mem.sv
rtl/ccm_mem.sv
tb/ccm_mem_props.sv
tb/ccm_mem_tb.sv
